// File: soc_pkg.sv
// Shared bus types, address map and fixed constants, imported by every subsystem module
package soc_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  rom_idx_t;
  typedef logic [5:0]  spm_idx_t;
  typedef logic [31:0] mtime_t;

  // Single-beat system bus, one request and one response per transfer
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t strb;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam addr_t ROM_BASE   = 32'h0000_1000;
  localparam int    ROM_WORDS  = 16;
  localparam addr_t SPM_BASE   = 32'h8000_0000;
  localparam int    SPM_WORDS  = 64;
  localparam addr_t CLINT_BASE = 32'h0200_0000;
  localparam addr_t CLINT_SIZE = 32'h0000_0010;

  // CLINT register offsets within its window
  localparam logic [3:0] CLINT_MSIP_OFS     = 4'h0;
  localparam logic [3:0] CLINT_MTIMECMP_OFS = 4'h4;
  localparam logic [3:0] CLINT_MTIME_OFS    = 4'h8;

  // Boot stub, then filler words with distinct patterns
  localparam data_t ROM_IMAGE [ROM_WORDS] = '{
    32'h0000_0297, 32'h0202_8293, 32'hf140_2573, 32'h8000_05b7,
    32'h0005_8067, 32'h1050_0073, 32'hffdf_f06f, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'hdead_beef, 32'hcafe_f00d,
    32'h1234_5678, 32'h9abc_def0, 32'h0bad_c0de, 32'h5a5a_a5a5
  };

  // Cycles after reset during which debug requests are held off
  localparam int DBG_DELAY_CYCLES = 20;

endpackage

// File: bus_arbiter.sv
// Round-robin arbiter, merges host and debug masters onto the system bus and routes responses
`timescale 1ns/1ps

module bus_arbiter (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  soc_pkg::bus_req_t host_req_i,
  input  logic              host_valid_i,
  output logic              host_ready_o,
  input  soc_pkg::bus_req_t dbg_req_i,
  input  logic              dbg_valid_i,
  output logic              dbg_ready_o,
  output soc_pkg::bus_rsp_t host_rsp_o,
  output logic              host_rsp_valid_o,
  output soc_pkg::bus_rsp_t dbg_rsp_o,
  output logic              dbg_rsp_valid_o,
  output soc_pkg::bus_req_t bus_req_o,
  output logic              bus_valid_o,
  input  soc_pkg::bus_rsp_t bus_rsp_i,
  input  logic              bus_rsp_valid_i
);
  import soc_pkg::*;

  // Set when the debug port won the most recent transfer
  logic last_dbg_q;
  // Owner of the transfer whose response arrives this cycle
  logic owner_dbg_q;

  // ----------------------------------------
  // Grant
  // ----------------------------------------
  // On a tie the port not granted last wins
  assign host_ready_o = host_valid_i & (~dbg_valid_i | last_dbg_q);
  assign dbg_ready_o  = dbg_valid_i & (~host_valid_i | ~last_dbg_q);

  assign bus_valid_o = host_ready_o | dbg_ready_o;
  assign bus_req_o   = dbg_ready_o ? dbg_req_i : host_req_i;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      last_dbg_q  <= 1'b1;
      owner_dbg_q <= 1'b0;
    end else begin
      // Sampled every cycle, only meaningful when a response follows
      owner_dbg_q <= dbg_ready_o;
      if (bus_valid_o) begin
        last_dbg_q <= dbg_ready_o;
      end
    end
  end

  // ----------------------------------------
  // Response return
  // ----------------------------------------
  assign host_rsp_o       = bus_rsp_i;
  assign dbg_rsp_o        = bus_rsp_i;
  assign host_rsp_valid_o = bus_rsp_valid_i & ~owner_dbg_q;
  assign dbg_rsp_valid_o  = bus_rsp_valid_i & owner_dbg_q;

endmodule

// File: addr_decoder.sv
// Address decoder, selects one target per transfer and forms the registered bus response
`timescale 1ns/1ps

module addr_decoder (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  soc_pkg::bus_req_t bus_req_i,
  input  logic              bus_valid_i,
  output soc_pkg::bus_rsp_t bus_rsp_o,
  output logic              bus_rsp_valid_o,
  output logic              rom_sel_o,
  output soc_pkg::rom_idx_t rom_idx_o,
  input  soc_pkg::data_t    rom_rdata_i,
  output logic              spm_sel_o,
  output soc_pkg::spm_idx_t spm_idx_o,
  input  soc_pkg::data_t    spm_rdata_i,
  output logic              clint_sel_o,
  output logic [3:0]        clint_ofs_o,
  input  soc_pkg::data_t    clint_rdata_i,
  output logic              we_o,
  output soc_pkg::data_t    wdata_o,
  output soc_pkg::strb_t    strb_o
);
  import soc_pkg::*;

  addr_t rom_ofs;
  addr_t spm_ofs;
  addr_t clint_ofs;
  logic  miss;
  logic  valid_q;
  logic  rom_q;
  logic  spm_q;
  logic  clint_q;
  logic  miss_q;

  // Offsets wrap below the base, so one compare checks both bounds
  assign rom_ofs   = bus_req_i.addr - ROM_BASE;
  assign spm_ofs   = bus_req_i.addr - SPM_BASE;
  assign clint_ofs = bus_req_i.addr - CLINT_BASE;

  // ROM writes fall through to the miss path
  assign rom_sel_o   = bus_valid_i & ~bus_req_i.we & (rom_ofs < addr_t'(ROM_WORDS * 4));
  assign spm_sel_o   = bus_valid_i & (spm_ofs < addr_t'(SPM_WORDS * 4));
  assign clint_sel_o = bus_valid_i & (clint_ofs < CLINT_SIZE);
  assign miss        = bus_valid_i & ~(rom_sel_o | spm_sel_o | clint_sel_o);

  assign rom_idx_o   = rom_ofs[5:2];
  assign spm_idx_o   = spm_ofs[7:2];
  assign clint_ofs_o = clint_ofs[3:0];
  assign we_o        = bus_req_i.we;
  assign wdata_o     = bus_req_i.wdata;
  assign strb_o      = bus_req_i.strb;

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      rom_q   <= 1'b0;
      spm_q   <= 1'b0;
      clint_q <= 1'b0;
      miss_q  <= 1'b0;
    end else begin
      valid_q <= bus_valid_i;
      rom_q   <= rom_sel_o;
      spm_q   <= spm_sel_o;
      clint_q <= clint_sel_o;
      miss_q  <= miss;
    end
  end

  always_comb begin
    bus_rsp_o.rdata = '0;
    if (rom_q) begin
      bus_rsp_o.rdata = rom_rdata_i;
    end else if (spm_q) begin
      bus_rsp_o.rdata = spm_rdata_i;
    end else if (clint_q) begin
      bus_rsp_o.rdata = clint_rdata_i;
    end
    bus_rsp_o.err = miss_q;
  end

  assign bus_rsp_valid_o = valid_q;

endmodule

// File: boot_rom.sv
// Boot ROM holding the fixed image, read one cycle after select
`timescale 1ns/1ps

module boot_rom (
  input  logic              clk_i,
  input  logic              rom_sel_i,
  input  soc_pkg::rom_idx_t rom_idx_i,
  output soc_pkg::data_t    rdata_o
);
  import soc_pkg::*;

  // Output holds the last word read between accesses
  always_ff @(posedge clk_i) begin
    if (rom_sel_i) begin
      rdata_o <= ROM_IMAGE[rom_idx_i];
    end
  end

endmodule

// File: scratchpad.sv
// Scratchpad word memory with byte-strobed writes and a registered read port
`timescale 1ns/1ps

module scratchpad (
  input  logic              clk_i,
  input  logic              spm_sel_i,
  input  soc_pkg::spm_idx_t spm_idx_i,
  input  logic              we_i,
  input  soc_pkg::data_t    wdata_i,
  input  soc_pkg::strb_t    strb_i,
  output soc_pkg::data_t    rdata_o
);
  import soc_pkg::*;

  data_t mem [SPM_WORDS];

  always_ff @(posedge clk_i) begin
    if (spm_sel_i) begin
      if (we_i) begin
        // Only strobed byte lanes change
        for (int b = 0; b < 4; b++) begin
          if (strb_i[b]) begin
            mem[spm_idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
      // Read returns the word as it was before this cycle's write
      rdata_o <= mem[spm_idx_i];
    end
  end

endmodule

// File: clint_timer.sv
// Core-local interruptor with machine timer, compare register and software interrupt
`timescale 1ns/1ps

module clint_timer (
  input  logic           clk_i,
  input  logic           ndmreset_n,
  input  logic           rtc_i,
  input  logic           clint_sel_i,
  input  logic [3:0]     clint_ofs_i,
  input  logic           we_i,
  input  soc_pkg::data_t wdata_i,
  output soc_pkg::data_t rdata_o,
  output logic           timer_irq_o,
  output logic           ipi_o
);
  import soc_pkg::*;

  logic [1:0] rtc_sync_q;
  logic       rtc_prev_q;
  logic       rtc_rise;
  logic       div_q;
  logic       msip_q;
  mtime_t     mtime_q;
  mtime_t     mtimecmp_q;
  logic       wr_en;

  // ----------------------------------------
  // RTC sync and divide by two
  // ----------------------------------------
  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;
  assign wr_en    = clint_sel_i & we_i;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q  <= '0;
      rtc_prev_q  <= 1'b0;
      div_q       <= 1'b0;
      msip_q      <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        div_q <= ~div_q;
      end
      // Software write of mtime wins over a tick in the same cycle
      if (wr_en && clint_ofs_i == CLINT_MTIME_OFS) begin
        mtime_q <= wdata_i;
      end else if (rtc_rise && div_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && clint_ofs_i == CLINT_MSIP_OFS) begin
        msip_q <= wdata_i[0];
      end
      if (wr_en && clint_ofs_i == CLINT_MTIMECMP_OFS) begin
        mtimecmp_q <= wdata_i;
      end
      timer_irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  assign ipi_o = msip_q;

  // Register read port
  always_ff @(posedge clk_i) begin
    if (clint_sel_i) begin
      case (clint_ofs_i)
        CLINT_MSIP_OFS:     rdata_o <= {31'b0, msip_q};
        CLINT_MTIMECMP_OFS: rdata_o <= mtimecmp_q;
        CLINT_MTIME_OFS:    rdata_o <= mtime_q;
        default:            rdata_o <= '0;
      endcase
    end
  end

endmodule

// File: debug_req_gate.sv
// Holds off the external debug request for a fixed window after reset
`timescale 1ns/1ps

module debug_req_gate (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);
  import soc_pkg::*;

  typedef logic [$clog2(DBG_DELAY_CYCLES+1)-1:0] dly_cnt_t;

  dly_cnt_t cnt_q;

  // Counts down once per cycle and stops at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= dly_cnt_t'(DBG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) & debug_req_i;

endmodule

// File: soc_top.sv
// Subsystem top level, connects the arbiter, decoder, memories, CLINT and debug gate
`timescale 1ns/1ps

module soc_top (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              rtc_i,
  input  soc_pkg::bus_req_t host_req_i,
  input  logic              host_valid_i,
  output logic              host_ready_o,
  output soc_pkg::bus_rsp_t host_rsp_o,
  output logic              host_rsp_valid_o,
  input  soc_pkg::bus_req_t dbg_req_i,
  input  logic              dbg_valid_i,
  output logic              dbg_ready_o,
  output soc_pkg::bus_rsp_t dbg_rsp_o,
  output logic              dbg_rsp_valid_o,
  input  logic              debug_req_i,
  output logic              debug_req_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);
  import soc_pkg::*;

  bus_req_t   bus_req;
  logic       bus_valid;
  bus_rsp_t   bus_rsp;
  logic       bus_rsp_valid;
  logic       rom_sel;
  rom_idx_t   rom_idx;
  data_t      rom_rdata;
  logic       spm_sel;
  spm_idx_t   spm_idx;
  data_t      spm_rdata;
  logic       clint_sel;
  logic [3:0] clint_ofs;
  data_t      clint_rdata;
  logic       we;
  data_t      wdata;
  strb_t      strb;

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------
  bus_arbiter i_bus_arbiter (
    .clk_i            ( clk_i            ),
    .ndmreset_n       ( ndmreset_n       ),
    .host_req_i       ( host_req_i       ),
    .host_valid_i     ( host_valid_i     ),
    .host_ready_o     ( host_ready_o     ),
    .dbg_req_i        ( dbg_req_i        ),
    .dbg_valid_i      ( dbg_valid_i      ),
    .dbg_ready_o      ( dbg_ready_o      ),
    .host_rsp_o       ( host_rsp_o       ),
    .host_rsp_valid_o ( host_rsp_valid_o ),
    .dbg_rsp_o        ( dbg_rsp_o        ),
    .dbg_rsp_valid_o  ( dbg_rsp_valid_o  ),
    .bus_req_o        ( bus_req          ),
    .bus_valid_o      ( bus_valid        ),
    .bus_rsp_i        ( bus_rsp          ),
    .bus_rsp_valid_i  ( bus_rsp_valid    )
  );

  addr_decoder i_addr_decoder (
    .clk_i           ( clk_i         ),
    .ndmreset_n      ( ndmreset_n    ),
    .bus_req_i       ( bus_req       ),
    .bus_valid_i     ( bus_valid     ),
    .bus_rsp_o       ( bus_rsp       ),
    .bus_rsp_valid_o ( bus_rsp_valid ),
    .rom_sel_o       ( rom_sel       ),
    .rom_idx_o       ( rom_idx       ),
    .rom_rdata_i     ( rom_rdata     ),
    .spm_sel_o       ( spm_sel       ),
    .spm_idx_o       ( spm_idx       ),
    .spm_rdata_i     ( spm_rdata     ),
    .clint_sel_o     ( clint_sel     ),
    .clint_ofs_o     ( clint_ofs     ),
    .clint_rdata_i   ( clint_rdata   ),
    .we_o            ( we            ),
    .wdata_o         ( wdata         ),
    .strb_o          ( strb          )
  );

  // ----------------------------------------
  // Targets
  // ----------------------------------------
  boot_rom i_boot_rom (
    .clk_i     ( clk_i     ),
    .rom_sel_i ( rom_sel   ),
    .rom_idx_i ( rom_idx   ),
    .rdata_o   ( rom_rdata )
  );

  scratchpad i_scratchpad (
    .clk_i     ( clk_i     ),
    .spm_sel_i ( spm_sel   ),
    .spm_idx_i ( spm_idx   ),
    .we_i      ( we        ),
    .wdata_i   ( wdata     ),
    .strb_i    ( strb      ),
    .rdata_o   ( spm_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .clint_sel_i ( clint_sel   ),
    .clint_ofs_i ( clint_ofs   ),
    .we_i        ( we          ),
    .wdata_i     ( wdata       ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // Debug request to the core
  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: soc_properties.sv
// Arbiter handshake assertions, attached to bus_arbiter by a bind in the testbench
`timescale 1ns/1ps

module soc_properties (
  input logic clk_i,
  input logic ndmreset_n,
  input logic host_ready_i,
  input logic dbg_ready_i,
  input logic host_rsp_valid_i,
  input logic dbg_rsp_valid_i
);

  // One master moves per cycle
  a_ready_exclusive: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(host_ready_i && dbg_ready_i))
    else $error("host and debug ready asserted in the same cycle");

  // Each transfer gets exactly one response on its own port one cycle later
  a_host_rsp_next: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    host_ready_i |=> (host_rsp_valid_i && !dbg_rsp_valid_i))
    else $error("host transfer not followed by a single host response");

  a_dbg_rsp_next: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    dbg_ready_i |=> (dbg_rsp_valid_i && !host_rsp_valid_i))
    else $error("debug transfer not followed by a single debug response");

  a_no_stray_rsp: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (!host_ready_i && !dbg_ready_i) |=> (!host_rsp_valid_i && !dbg_rsp_valid_i))
    else $error("response valid without a transfer in the previous cycle");

  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(ndmreset_n) |-> (!host_rsp_valid_i && !dbg_rsp_valid_i))
    else $error("response valid in the first cycle after reset");

endmodule

// File: tb_soc_top.sv
// Directed testbench for soc_top, built from list.f with the Makefile in the project root
`timescale 1ns/1ps

module tb_soc_top;
  import soc_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RTC_TICKS      = 3;

  logic     clk_i = 1'b0;
  logic     ndmreset_n;
  logic     rtc_i;
  bus_req_t host_req;
  logic     host_valid;
  logic     host_ready;
  bus_rsp_t host_rsp;
  logic     host_rsp_valid;
  bus_req_t dbg_req;
  logic     dbg_valid;
  logic     dbg_ready;
  bus_rsp_t dbg_rsp;
  logic     dbg_rsp_valid;
  logic     debug_req_i;
  logic     debug_req_o;
  logic     timer_irq;
  logic     ipi;
  int       errors = 0;
  int       checks = 0;
  int       cycle_cnt = 0;
  integer   seed;
  data_t    spm_model [SPM_WORDS];

  soc_top DUT (
    .clk_i, .ndmreset_n, .rtc_i,
    .host_req_i (host_req), .host_valid_i (host_valid), .host_ready_o (host_ready),
    .host_rsp_o (host_rsp), .host_rsp_valid_o (host_rsp_valid),
    .dbg_req_i (dbg_req), .dbg_valid_i (dbg_valid), .dbg_ready_o (dbg_ready),
    .dbg_rsp_o (dbg_rsp), .dbg_rsp_valid_o (dbg_rsp_valid),
    .debug_req_i, .debug_req_o, .timer_irq_o (timer_irq), .ipi_o (ipi)
  );

  bind bus_arbiter soc_properties i_soc_properties (
    .clk_i (clk_i), .ndmreset_n (ndmreset_n),
    .host_ready_i (host_ready_o), .dbg_ready_i (dbg_ready_o),
    .host_rsp_valid_i (host_rsp_valid_o), .dbg_rsp_valid_i (dbg_rsp_valid_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_data(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0d ns: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0d ns: %s err is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // Bus drivers
  // ----------------------------------------
  function automatic bus_req_t make_req(input addr_t addr, input logic we, input data_t wdata,
                                        input strb_t strb);
    bus_req_t req;
    req.addr  = addr;
    req.we    = we;
    req.wdata = wdata;
    req.strb  = strb;
    return req;
  endfunction

  // Drives one transfer and samples its response at the falling edge after acceptance
  task automatic bus_access(input logic use_dbg, input bus_req_t req, output bus_rsp_t rsp);
    @(negedge clk_i);
    if (use_dbg) begin
      dbg_req   = req;
      dbg_valid = 1'b1;
    end else begin
      host_req   = req;
      host_valid = 1'b1;
    end
    #1;
    while (!(use_dbg ? dbg_ready : host_ready)) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    host_valid = 1'b0;
    dbg_valid  = 1'b0;
    rsp = use_dbg ? dbg_rsp : host_rsp;
    if (!(use_dbg ? dbg_rsp_valid : host_rsp_valid)) begin
      errors++;
      $display("No response arrived on the %s port in the cycle after its transfer",
               use_dbg ? "debug" : "host");
    end
  endtask

  task automatic host_access(input bus_req_t req, output bus_rsp_t rsp);
    bus_access(1'b0, req, rsp);
  endtask

  task automatic dbg_access(input bus_req_t req, output bus_rsp_t rsp);
    bus_access(1'b1, req, rsp);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_debug_gate();
    check_bit("debug_req_o at reset release", debug_req_o, 1'b0);
    for (int k = 1; k <= DBG_DELAY_CYCLES + 4; k++) begin
      @(negedge clk_i);
      check_bit("debug_req_o after reset", debug_req_o, k >= DBG_DELAY_CYCLES);
    end
    // Past the window the request follows its input
    debug_req_i = 1'b0;
    #1;
    check_bit("debug_req_o with debug_req_i low", debug_req_o, 1'b0);
    @(negedge clk_i);
    debug_req_i = 1'b1;
    #1;
    check_bit("debug_req_o with debug_req_i high", debug_req_o, 1'b1);
    $display("Test debug gate finished, %0d errors so far", errors);
  endtask

  task automatic test_rom_and_errors();
    bus_rsp_t rsp;
    for (int i = 0; i < ROM_WORDS; i++) begin
      host_access(make_req(ROM_BASE + addr_t'(4 * i), 1'b0, '0, '0), rsp);
      check_data("ROM read", rsp.rdata, ROM_IMAGE[rom_idx_t'(i)]);
      check_err("ROM read", rsp.err, 1'b0);
    end
    host_access(make_req(ROM_BASE + 32'h8, 1'b1, 32'h1111_2222, 4'hf), rsp);
    check_data("ROM write", rsp.rdata, '0);
    check_err("ROM write", rsp.err, 1'b1);
    dbg_access(make_req(32'h4000_0000, 1'b0, '0, '0), rsp);
    check_data("Unmapped read", rsp.rdata, '0);
    check_err("Unmapped read", rsp.err, 1'b1);
    $display("Test boot ROM and errors finished, %0d errors so far", errors);
  endtask

  task automatic test_scratchpad();
    bus_rsp_t rsp;
    logic [31:0] r;
    spm_idx_t idx;
    strb_t strb;
    data_t wdata;
    data_t mask;
    addr_t addr;
    // Full-word fill so every byte has a known value
    for (int i = 0; i < SPM_WORDS; i++) begin
      r = $random(seed);
      spm_model[spm_idx_t'(i)] = r;
      host_access(make_req(SPM_BASE + addr_t'(4 * i), 1'b1, r, 4'hf), rsp);
      check_err("SPM fill write", rsp.err, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      r     = $random(seed);
      idx   = r[5:0];
      strb  = r[11:8];
      wdata = $random(seed);
      addr  = SPM_BASE + {24'h0, idx, 2'b00};
      mask  = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      // Write from one port and read back from the other
      bus_access(i[0], make_req(addr, 1'b1, wdata, strb), rsp);
      check_err("SPM strobed write", rsp.err, 1'b0);
      spm_model[idx] = (spm_model[idx] & ~mask) | (wdata & mask);
      bus_access(~i[0], make_req(addr, 1'b0, '0, '0), rsp);
      check_data("SPM strobed readback", rsp.rdata, spm_model[idx]);
    end
    $display("Test scratchpad strobes finished, %0d errors so far", errors);
  endtask

  task automatic test_arbitration();
    bus_rsp_t rsp;
    // Grant the debug port last so the host wins the first tie
    dbg_access(make_req(SPM_BASE, 1'b0, '0, '0), rsp);
    @(negedge clk_i);
    host_req   = make_req(SPM_BASE + 32'h4, 1'b0, '0, '0);
    dbg_req    = make_req(SPM_BASE + 32'h8, 1'b0, '0, '0);
    host_valid = 1'b1;
    dbg_valid  = 1'b1;
    for (int c = 0; c < 8; c++) begin
      #1;
      check_bit("host ready under contention", host_ready, c % 2 == 0);
      check_bit("debug ready under contention", dbg_ready, c % 2 == 1);
      @(negedge clk_i);
      check_bit("host response valid", host_rsp_valid, c % 2 == 0);
      check_bit("debug response valid", dbg_rsp_valid, c % 2 == 1);
      if (c % 2 == 0) begin
        check_data("host read under contention", host_rsp.rdata, spm_model[1]);
      end else begin
        check_data("debug read under contention", dbg_rsp.rdata, spm_model[2]);
      end
    end
    host_valid = 1'b0;
    dbg_valid  = 1'b0;
    $display("Test arbitration finished, %0d errors so far", errors);
  endtask

  task automatic test_clint();
    bus_rsp_t rsp;
    check_bit("timer_irq_o after reset", timer_irq, 1'b0);
    check_bit("ipi_o after reset", ipi, 1'b0);
    host_access(make_req(CLINT_BASE + addr_t'(CLINT_MSIP_OFS), 1'b1, 32'h1, 4'hf), rsp);
    check_bit("ipi_o after msip set", ipi, 1'b1);
    // Nonzero first, so the later clear of mtime is visible
    host_access(make_req(CLINT_BASE + addr_t'(CLINT_MTIME_OFS), 1'b1, 32'h40, 4'hf), rsp);
    host_access(make_req(CLINT_BASE + addr_t'(CLINT_MTIME_OFS), 1'b0, '0, '0), rsp);
    check_data("mtime after write", rsp.rdata, 32'h40);
    host_access(make_req(CLINT_BASE + addr_t'(CLINT_MTIME_OFS), 1'b1, '0, 4'hf), rsp);
    // Four clock cycles per rtc phase leave room for the two-flop synchronizer
    for (int e = 0; e < 2 * RTC_TICKS; e++) begin
      repeat (4) @(negedge clk_i);
      rtc_i = 1'b1;
      repeat (4) @(negedge clk_i);
      rtc_i = 1'b0;
    end
    repeat (4) @(negedge clk_i);
    host_access(make_req(CLINT_BASE + addr_t'(CLINT_MTIME_OFS), 1'b0, '0, '0), rsp);
    check_data("mtime after rtc edges", rsp.rdata, data_t'(RTC_TICKS));
    host_access(make_req(CLINT_BASE + addr_t'(CLINT_MTIMECMP_OFS), 1'b1,
                         data_t'(RTC_TICKS), 4'hf), rsp);
    @(negedge clk_i);
    check_bit("timer_irq_o with mtimecmp at mtime", timer_irq, 1'b1);
    host_access(make_req(CLINT_BASE + addr_t'(CLINT_MTIMECMP_OFS), 1'b1,
                         data_t'(RTC_TICKS + 100), 4'hf), rsp);
    @(negedge clk_i);
    check_bit("timer_irq_o with mtimecmp above mtime", timer_irq, 1'b0);
    host_access(make_req(CLINT_BASE + addr_t'(CLINT_MSIP_OFS), 1'b1, '0, 4'hf), rsp);
    check_bit("ipi_o after msip clear", ipi, 1'b0);
    $display("Test CLINT finished, %0d errors so far", errors);
  endtask

  initial begin
    seed        = 32'ha8f357ee;
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    host_req    = '0;
    host_valid  = 1'b0;
    dbg_req     = '0;
    dbg_valid   = 1'b0;
    debug_req_i = 1'b1;
    repeat (5) @(negedge clk_i);
    ndmreset_n = 1'b1;
    test_debug_gate();
    test_rom_and_errors();
    test_scratchpad();
    test_arbitration();
    test_clint();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: list.f
soc_pkg.sv
bus_arbiter.sv
addr_decoder.sv
boot_rom.sv
scratchpad.sv
clint_timer.sv
debug_req_gate.sv
soc_top.sv
soc_properties.sv
tb_soc_top.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_soc_top
FILELIST   = list.f

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
